/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= icache_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

SOURCES := $(wildcard hw/*.sv hw/*.svh verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+hw
hw/ic_cpu_pkg.sv
hw/ic_mem_pkg.sv
hw/ic_fetch_front.sv
hw/ic_lookup.sv
hw/ic_refill_master.sv
hw/icache_top.sv
verif/icache_mem_model.sv
verif/icache_tb.sv

/* hw/ic_cpu_pkg.sv */
`include "ic_defs.svh"

package ic_cpu_pkg;

    typedef struct packed {
        logic [`IC_ADDR_W-1:0] vaddr;
        logic [`IC_TAG_W-1:0]  pfn;
        logic                  no_cache;   // bypass, single beat read
    } fetch_req_t;

    typedef struct packed {
        logic                  valid;      // one-cycle pulse
        logic [`IC_DATA_W-1:0] data;
    } fetch_rsp_t;

    typedef enum logic [1:0] {
        MAINT_NONE      = 2'd0,
        MAINT_INDEX_INV = 2'd1,
        MAINT_HIT_INV   = 2'd2
    } maint_kind_e;

    // address as seen by a hit invalidate
    typedef struct packed {
        logic [`IC_TAG_W-1:0]      tag;
        logic [`IC_LINE_PAD_W-1:0] pad;
        logic [`IC_INDEX_W-1:0]    index;
        logic [`IC_OFFSET_W-1:0]   offset;
    } maint_line_t;

    // address as seen by an index invalidate, way sits just above index
    typedef struct packed {
        logic [`IC_SEL_PAD_W-1:0] unused;
        logic [`IC_WAY_W-1:0]     way;
        logic [`IC_INDEX_W-1:0]   index;
        logic [`IC_OFFSET_W-1:0]  offset;
    } maint_sel_t;

    typedef union packed {
        maint_line_t line_view;
        maint_sel_t  index_view;
    } maint_addr_u;

    typedef struct packed {
        maint_kind_e kind;
        maint_addr_u addr;
    } maint_op_t;

endpackage

/* hw/ic_defs.svh */
`ifndef IC_DEFS_SVH
`define IC_DEFS_SVH

// cache geometry
`define IC_WAYS     4
`define IC_WAY_W    2
`define IC_INDEX_W  4        // 16 sets
`define IC_OFFSET_W 5        // byte offset inside a line
`define IC_TAG_W    20       // tag is the frame number

// bus widths
`define IC_ADDR_W   32
`define IC_DATA_W   32
`define IC_LEN_W    4

// line layout
`define IC_BEATS    8        // words per line
`define IC_WORD_W   3
`define IC_BURST_LEN 4'd7    // arlen of a full line refill

// gaps in the two views of a maintenance address
`define IC_LINE_PAD_W (`IC_ADDR_W - `IC_TAG_W - `IC_INDEX_W - `IC_OFFSET_W)
`define IC_SEL_PAD_W  (`IC_ADDR_W - `IC_WAY_W - `IC_INDEX_W - `IC_OFFSET_W)

`endif

/* hw/ic_fetch_front.sv */
`timescale 1ns/1ps

module ic_fetch_front (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  ic_cpu_pkg::fetch_req_t fetch_req,
    output logic                   fetch_ready,
    input  logic                   maint_valid,
    input  ic_cpu_pkg::maint_op_t  maint_op,
    output logic                   maint_ready,
    input  logic                   done,
    output logic                   cur_valid,
    output ic_cpu_pkg::fetch_req_t cur_req,
    output ic_cpu_pkg::maint_op_t  cur_maint
);

    logic busy;
    logic take_fetch;
    logic take_maint;

    assign maint_ready = ~busy;
    assign fetch_ready = ~busy & ~maint_valid;   // maintenance goes first

    // an op of kind none is accepted and dropped
    assign take_maint = maint_valid & maint_ready & (maint_op.kind != ic_cpu_pkg::MAINT_NONE);
    assign take_fetch = fetch_valid & fetch_ready;

    assign cur_valid = busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
        end else if (take_maint || take_fetch) begin
            busy <= 1'b1;
        end else if (done) begin
            busy <= 1'b0;                        // lookup finished
        end
    end

    // held request
    always_ff @(posedge clk) begin
        if (take_fetch) begin
            cur_req <= fetch_req;
        end
        if (take_maint) begin
            cur_maint <= maint_op;
        end else if (take_fetch) begin
            cur_maint.kind <= ic_cpu_pkg::MAINT_NONE;   // marks a plain fetch
        end
    end

    a_done_busy: assert property (@(posedge clk) disable iff (rst) done |-> busy)
        else $error("done while front idle");

endmodule

/* hw/ic_lookup.sv */
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_lookup (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cur_valid,
    input  ic_cpu_pkg::fetch_req_t   cur_req,
    input  ic_cpu_pkg::maint_op_t    cur_maint,
    output logic                     done,
    output ic_cpu_pkg::fetch_rsp_t   fetch_rsp,
    output logic                     refill_go,
    output ic_mem_pkg::refill_req_t  refill_req,
    input  ic_mem_pkg::refill_beat_t refill_beat
);

    localparam int SETS   = 1 << `IC_INDEX_W;
    localparam int PAGE_W = `IC_ADDR_W - `IC_TAG_W;
    localparam int LINE_W = `IC_INDEX_W + `IC_OFFSET_W;

    logic [`IC_TAG_W-1:0]  tag_q  [`IC_WAYS][SETS];
    logic [`IC_DATA_W-1:0] data_q [`IC_WAYS][SETS][`IC_BEATS];
    logic [`IC_WAYS-1:0][SETS-1:0] valid_q;
    logic [2:0]            plru_q [SETS];        // b0 picks the half

    logic                  is_maint;
    logic [`IC_INDEX_W-1:0] index;
    logic [`IC_TAG_W-1:0]  tag;
    logic [`IC_WORD_W-1:0] word;
    logic [`IC_WAYS-1:0]   hit_mask;
    logic [`IC_WAY_W-1:0]  hit_way;
    logic [`IC_WAY_W-1:0]  victim;
    logic [`IC_WAY_W-1:0]  access_way;
    logic [2:0]            plru;
    logic                  pending;              // refill issued, waiting for last beat
    logic                  hit_fire;
    logic                  fill_last;
    logic                  fill_en;
    logic                  beat_is_word;
    logic [`IC_DATA_W-1:0] saved_word;
    logic [`IC_DATA_W-1:0] rsp_word;
    logic [`IC_DATA_W-1:0] rsp_data_q;
    logic                  rsp_valid_q;

    assign is_maint = cur_maint.kind != ic_cpu_pkg::MAINT_NONE;
    assign index = is_maint ? cur_maint.addr.line_view.index
                            : cur_req.vaddr[LINE_W-1:`IC_OFFSET_W];
    assign tag   = is_maint ? cur_maint.addr.line_view.tag : cur_req.pfn;
    assign word  = cur_req.vaddr[`IC_OFFSET_W-1:2];
    assign plru  = plru_q[index];

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `IC_WAYS; w++) begin
            hit_mask[w] = valid_q[w][index] && (tag_q[w][index] == tag);
            if (hit_mask[w]) begin
                hit_way = w[`IC_WAY_W-1:0];
            end
        end
    end

    assign victim = plru[0] ? {1'b1, plru[2]} : {1'b0, plru[1]};

    assign hit_fire  = cur_valid & ~is_maint & ~cur_req.no_cache & ~pending & (|hit_mask);
    assign refill_go = cur_valid & ~is_maint & ~pending & (cur_req.no_cache | ~(|hit_mask));
    assign fill_last = refill_beat.valid & refill_beat.last;
    assign fill_en   = refill_beat.valid & ~cur_req.no_cache;
    assign done      = cur_valid & (is_maint | hit_fire | fill_last);
    assign access_way = hit_fire ? hit_way : victim;
    assign beat_is_word = refill_beat.valid & (refill_beat.idx == word);

    // line aligned burst, or the exact word when uncached
    assign refill_req.addr = cur_req.no_cache ?
        {cur_req.pfn, cur_req.vaddr[PAGE_W-1:0]} :
        {cur_req.pfn, cur_req.vaddr[PAGE_W-1:`IC_OFFSET_W], {`IC_OFFSET_W{1'b0}}};
    assign refill_req.len  = cur_req.no_cache ? '0 : `IC_BURST_LEN;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else if (done) begin
            pending <= 1'b0;
        end else if (refill_go) begin
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (cur_valid && cur_maint.kind == ic_cpu_pkg::MAINT_INDEX_INV) begin
            valid_q[cur_maint.addr.index_view.way][index] <= 1'b0;
        end else if (cur_valid && cur_maint.kind == ic_cpu_pkg::MAINT_HIT_INV) begin
            for (int w = 0; w < `IC_WAYS; w++) begin
                if (hit_mask[w]) begin
                    valid_q[w][index] <= 1'b0;     // matching way only
                end
            end
        end else if (fill_en && fill_last) begin
            valid_q[victim][index] <= 1'b1;
        end
    end

    // hits and fills both count as accesses
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                plru_q[s] <= 3'b000;
            end
        end else if (hit_fire || (fill_en && fill_last)) begin
            plru_q[index][0] <= ~access_way[1];
            if (access_way[1]) begin
                plru_q[index][2] <= ~access_way[0];
            end else begin
                plru_q[index][1] <= ~access_way[0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_q[victim][index][refill_beat.idx] <= refill_beat.data;
        end
        if (fill_en && fill_last) begin
            tag_q[victim][index] <= cur_req.pfn;
        end
        if (beat_is_word) begin
            saved_word <= refill_beat.data;      // requested word of the burst
        end
    end

    assign rsp_word = hit_fire ? data_q[hit_way][index][word] :
                      (cur_req.no_cache || beat_is_word) ? refill_beat.data : saved_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= done & ~is_maint;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rsp_data_q <= rsp_word;
        end
    end

    assign fetch_rsp.valid = rsp_valid_q;
    assign fetch_rsp.data  = rsp_data_q;

    a_hit_onehot: assert property (@(posedge clk) disable iff (rst)
        cur_valid |-> $onehot0(hit_mask))
        else $error("tag matches in more than one way");

endmodule

/* hw/ic_mem_pkg.sv */
`include "ic_defs.svh"

package ic_mem_pkg;

    // one burst read asked for by the lookup
    typedef struct packed {
        logic [`IC_ADDR_W-1:0] addr;
        logic [`IC_LEN_W-1:0]  len;        // beats minus one
    } refill_req_t;

    // one accepted read data beat, numbered inside the burst
    typedef struct packed {
        logic                  valid;
        logic [`IC_WORD_W-1:0] idx;
        logic [`IC_DATA_W-1:0] data;
        logic                  last;
    } refill_beat_t;

endpackage

/* hw/ic_refill_master.sv */
`timescale 1ns/1ps
`include "ic_defs.svh"

module ic_refill_master (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     refill_go,
    input  ic_mem_pkg::refill_req_t  refill_req,
    output ic_mem_pkg::refill_beat_t refill_beat,
    output logic [`IC_ADDR_W-1:0]    araddr,
    output logic [`IC_LEN_W-1:0]     arlen,
    output logic                     arvalid,
    input  logic                     arready,
    input  logic [`IC_DATA_W-1:0]    rdata,
    input  logic                     rlast,
    input  logic                     rvalid,
    output logic                     rready
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } state_e;

    state_e                state;
    logic [`IC_WORD_W-1:0] cnt;                  // word number in the burst
    logic [`IC_ADDR_W-1:0] addr_q;
    logic [`IC_LEN_W-1:0]  len_q;
    logic                  beat_take;

    assign arvalid   = (state == S_ADDR);
    assign rready    = (state == S_DATA);
    assign araddr    = addr_q;
    assign arlen     = len_q;
    assign beat_take = rvalid & rready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            case (state)
                S_IDLE: if (refill_go) state <= S_ADDR;
                S_ADDR: if (arready) state <= S_DATA;
                S_DATA: if (beat_take && rlast) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (state == S_IDLE) begin
            cnt <= '0;
        end else if (beat_take) begin
            cnt <= cnt + 1'b1;
        end
    end

    // address held until the channel takes it
    always_ff @(posedge clk) begin
        if (state == S_IDLE && refill_go) begin
            addr_q <= refill_req.addr;
            len_q  <= refill_req.len;
        end
    end

    assign refill_beat.valid = beat_take;
    assign refill_beat.idx   = cnt;
    assign refill_beat.data  = rdata;
    assign refill_beat.last  = beat_take & rlast;

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("read address dropped before acceptance");

endmodule

/* hw/icache_top.sv */
`timescale 1ns/1ps
`include "ic_defs.svh"

module icache_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetch_valid,
    input  ic_cpu_pkg::fetch_req_t fetch_req,
    output logic                   fetch_ready,
    output ic_cpu_pkg::fetch_rsp_t fetch_rsp,
    input  logic                   maint_valid,
    input  ic_cpu_pkg::maint_op_t  maint_op,
    output logic                   maint_ready,
    output logic [`IC_ADDR_W-1:0]  araddr,
    output logic [`IC_LEN_W-1:0]   arlen,
    output logic                   arvalid,
    input  logic                   arready,
    input  logic [`IC_DATA_W-1:0]  rdata,
    input  logic                   rlast,
    input  logic                   rvalid,
    output logic                   rready
);

    logic                     cur_valid;
    ic_cpu_pkg::fetch_req_t   cur_req;
    ic_cpu_pkg::maint_op_t    cur_maint;
    logic                     done;
    logic                     refill_go;
    ic_mem_pkg::refill_req_t  refill_req;
    ic_mem_pkg::refill_beat_t refill_beat;

    ic_fetch_front front_i (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_req(fetch_req), .fetch_ready(fetch_ready),
        .maint_valid(maint_valid), .maint_op(maint_op), .maint_ready(maint_ready),
        .done(done),
        .cur_valid(cur_valid), .cur_req(cur_req), .cur_maint(cur_maint)
    );

    ic_lookup lookup_i (
        .clk(clk), .rst(rst),
        .cur_valid(cur_valid), .cur_req(cur_req), .cur_maint(cur_maint),
        .done(done), .fetch_rsp(fetch_rsp),
        .refill_go(refill_go), .refill_req(refill_req), .refill_beat(refill_beat)
    );

    ic_refill_master master_i (
        .clk(clk), .rst(rst),
        .refill_go(refill_go), .refill_req(refill_req), .refill_beat(refill_beat),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

endmodule

/* verif/icache_mem_model.sv */
`timescale 1ns/1ps

module icache_mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic [3:0]  arlen,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rlast,
    output logic        rvalid,
    input  logic        rready
);

    logic        active;          // burst in progress
    logic [31:0] addr;            // word on the bus
    logic [3:0]  left;            // beats after the current one
    logic        ar_taken;
    logic        r_taken;
    logic [31:0] ar_addr_seen;
    logic [3:0]  ar_len_seen;

    initial begin
        arready      = 1'b0;
        rvalid       = 1'b0;
        rlast        = 1'b0;
        rdata        = '0;
        active       = 1'b0;
        addr         = '0;
        left         = '0;
        ar_taken     = 1'b0;
        r_taken      = 1'b0;
        ar_addr_seen = '0;
        ar_len_seen  = '0;
        forever begin
            @(posedge clk);
            #2;
            // transfers made at the edge just passed
            if (rst) begin
                active = 1'b0;
            end else if (ar_taken) begin
                active = 1'b1;
                addr   = ar_addr_seen;
                left   = ar_len_seen;
            end else if (r_taken) begin
                if (left == 4'd0) begin
                    active = 1'b0;
                end else begin
                    addr = addr + 32'd4;
                    left = left - 4'd1;
                end
            end
            arready = !active && (($urandom & 3) != 0);   // random gaps
            rvalid  = active && (($urandom & 3) != 0);
            rdata   = active ? ~{addr[31:2], 2'b00} : '0;
            rlast   = active && (left == 4'd0);
            // DUT side is registered, so these hold until the next edge
            ar_taken     = arvalid && arready;
            ar_addr_seen = araddr;
            ar_len_seen  = arlen;
            r_taken      = rvalid && rready;
        end
    end

endmodule

/* verif/icache_tb.sv */
`timescale 1ns/1ps

module icache_tb;

    localparam int CLK_PERIOD  = 40;
    localparam int N_PLRU_RAND = 16;
    localparam int N_RAND      = 30;
    localparam int N_REQ       = 4 + 3 + (5 + N_PLRU_RAND) + (8 + 2 + 5) + N_RAND;
    localparam int CYC_PER_REQ = 200;

    logic                   clk;
    logic                   rst;
    logic                   fetch_valid;
    ic_cpu_pkg::fetch_req_t fetch_req;
    logic                   fetch_ready;
    ic_cpu_pkg::fetch_rsp_t fetch_rsp;
    logic                   maint_valid;
    ic_cpu_pkg::maint_op_t  maint_op;
    logic                   maint_ready;
    logic [31:0]            araddr;
    logic [3:0]             arlen;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic                   rlast;
    logic                   rvalid;
    logic                   rready;

    // expectation for the request in flight
    logic        exp_hit;
    logic [31:0] exp_data;
    logic [31:0] exp_araddr;
    logic [3:0]  exp_arlen;
    logic        exp_rready;      // read data window of the burst
    logic        fetch_acc;
    logic        maint_acc;

    // cache state as the model sees it
    logic [19:0] m_tag   [16][4];
    logic        m_valid [16][4];
    logic [2:0]  m_plru  [16];
    logic [19:0] tag_pool [$];    // tags sharing set 9

    always #(CLK_PERIOD / 2) clk = ~clk;

    icache_top dut_i (
        .clk(clk), .rst(rst),
        .fetch_valid(fetch_valid), .fetch_req(fetch_req), .fetch_ready(fetch_ready),
        .fetch_rsp(fetch_rsp),
        .maint_valid(maint_valid), .maint_op(maint_op), .maint_ready(maint_ready),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    icache_mem_model mem_i (
        .clk(clk), .rst(rst),
        .araddr(araddr), .arlen(arlen), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rlast(rlast), .rvalid(rvalid), .rready(rready)
    );

    assign fetch_acc = fetch_valid && fetch_ready;
    assign maint_acc = maint_valid && maint_ready;

    // open at address acceptance, closed after the last beat
    always @(posedge clk) begin
        if (rst) begin
            exp_rready <= 1'b0;
        end else if (arvalid && arready) begin
            exp_rready <= 1'b1;
        end else if (exp_rready && rvalid && rlast) begin
            exp_rready <= 1'b0;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #2;
    endtask

    function automatic int find_way(input logic [3:0] idx, input logic [19:0] t);
        int found;
        found = -1;
        for (int w = 0; w < 4; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == t) begin
                found = w;
            end
        end
        return found;
    endfunction

    // b0 = 0 picks way b1, b0 = 1 picks way 2 + b2
    function automatic int plru_victim(input logic [3:0] idx);
        logic [2:0] b;
        b = m_plru[idx];
        if (b[0] == 1'b0) begin
            return b[1] ? 1 : 0;
        end
        return b[2] ? 3 : 2;
    endfunction

    function automatic void plru_touch(input logic [3:0] idx, input int way);
        m_plru[idx][0] = (way < 2);           // point away from the used half
        if (way < 2) begin
            m_plru[idx][1] = (way == 0);
        end else begin
            m_plru[idx][2] = (way == 2);
        end
    endfunction

    task automatic fetch_word(input logic [19:0] pfn, input int idx, input int wd,
                              input bit nc);
        logic [31:0] vaddr;
        logic [31:0] paddr;
        int          way;
        int          victim;
        vaddr       = $urandom;
        vaddr[11:0] = {3'b000, idx[3:0], wd[2:0], 2'b00};   // upper page offset bits kept zero
        paddr       = {pfn, vaddr[11:0]};
        way         = find_way(idx[3:0], pfn);
        exp_hit     = !nc && (way >= 0);
        exp_data    = ~paddr;
        exp_araddr  = nc ? paddr : {paddr[31:5], 5'b00000};
        exp_arlen   = nc ? 4'd0 : 4'd7;
        fetch_req.vaddr    = vaddr;
        fetch_req.pfn      = pfn;
        fetch_req.no_cache = nc;
        fetch_valid = 1'b1;
        while (!fetch_ready) begin
            step_cycle();
        end
        step_cycle();                                         // taken at this edge
        fetch_valid = 1'b0;
        if (!nc) begin
            if (way >= 0) begin
                plru_touch(idx[3:0], way);
            end else begin
                victim = plru_victim(idx[3:0]);
                m_tag[idx][victim]   = pfn;
                m_valid[idx][victim] = 1'b1;
                plru_touch(idx[3:0], victim);
            end
        end
        while (!fetch_rsp.valid) begin
            step_cycle();
        end
        step_cycle();
    endtask

    task automatic maint_run(input ic_cpu_pkg::maint_kind_e kind, input logic [19:0] t,
                             input int idx, input int way);
        ic_cpu_pkg::maint_op_t op;
        op      = '0;
        op.kind = kind;
        if (kind == ic_cpu_pkg::MAINT_INDEX_INV) begin
            op.addr.index_view.way   = way[1:0];
            op.addr.index_view.index = idx[3:0];
        end else begin
            op.addr.line_view.tag   = t;
            op.addr.line_view.index = idx[3:0];
        end
        maint_op    = op;
        maint_valid = 1'b1;
        while (!maint_ready) begin
            step_cycle();
        end
        step_cycle();
        maint_valid = 1'b0;
        if (kind == ic_cpu_pkg::MAINT_INDEX_INV) begin
            m_valid[idx][way] = 1'b0;
        end else begin
            for (int w = 0; w < 4; w++) begin
                if (m_tag[idx][w] == t) begin
                    m_valid[idx][w] = 1'b0;
                end
            end
        end
        while (!maint_ready) begin
            step_cycle();
        end
    endtask

    task automatic run_cold_and_hits();
        fetch_word(20'h12345, 3, 2, 1'b0);    // cold miss
        fetch_word(20'h12345, 3, 0, 1'b0);
        fetch_word(20'h12345, 3, 5, 1'b0);
        fetch_word(20'h12345, 3, 7, 1'b0);
    endtask

    task automatic run_uncached();
        fetch_word(20'h0abcd, 5, 3, 1'b1);
        fetch_word(20'h0abcd, 5, 3, 1'b0);    // nothing allocated, so a miss
        fetch_word(20'h0abcd, 5, 1, 1'b0);
    endtask

    task automatic run_plru();
        logic [19:0] t;
        int          pick;
        for (int i = 0; i < 5; i++) begin
            t      = 20'h30000;
            t[3:0] = i[3:0];
            tag_pool.push_back(t);
            fetch_word(t, 9, i, 1'b0);
        end
        for (int i = 0; i < N_PLRU_RAND; i++) begin
            pick = $urandom_range(4, 0);
            fetch_word(tag_pool[pick], 9, i % 8, 1'b0);
        end
    endtask

    task automatic run_maint();
        for (int w = 0; w < 4; w++) begin
            maint_run(ic_cpu_pkg::MAINT_INDEX_INV, 20'h0, 3, w);
            fetch_word(20'h12345, 3, w, 1'b0);
        end
        fetch_word(tag_pool[1], 9, 2, 1'b0);  // make sure it is resident
        maint_run(ic_cpu_pkg::MAINT_HIT_INV, tag_pool[1], 9, 0);
        for (int i = 4; i >= 0; i--) begin
            fetch_word(tag_pool[i], 9, 6, 1'b0);
        end
    endtask

    task automatic run_random();
        int          r;
        logic [19:0] pfn;
        for (int i = 0; i < N_RAND; i++) begin
            r        = $urandom_range(2, 0);
            pfn      = 20'h7f000;
            pfn[1:0] = r[1:0];
            fetch_word(pfn, $urandom_range(15, 0), $urandom_range(7, 0),
                       $urandom_range(7, 0) == 0);
        end
    endtask

    a_rsp_data: assert property (@(posedge clk) disable iff (rst)
        fetch_rsp.valid |-> fetch_rsp.data == exp_data)
        else stop_on_error($sformatf("** Error: fetch_rsp.data = %h, expected %h",
            $sampled(fetch_rsp.data), $sampled(exp_data)));

    a_ar_target: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> araddr == exp_araddr && arlen == exp_arlen)
        else stop_on_error($sformatf("** Error: araddr = %h arlen = %h, expected %h %h",
            $sampled(araddr), $sampled(arlen), $sampled(exp_araddr), $sampled(exp_arlen)));

    a_ar_steady: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else stop_on_error("read address withdrawn or changed before arready");

    a_rready: assert property (@(posedge clk) disable iff (rst)
        rready == exp_rready)
        else stop_on_error($sformatf("** Error: rready = %h, expected %h",
            $sampled(rready), $sampled(exp_rready)));

    a_hit_timing: assert property (@(posedge clk) disable iff (rst)
        fetch_acc && exp_hit |=> !fetch_ready ##1 (fetch_rsp.valid && fetch_ready))
        else stop_on_error("hit did not respond one cycle after acceptance");

    a_hit_no_burst: assert property (@(posedge clk) disable iff (rst)
        arvalid |-> !exp_hit)
        else stop_on_error("burst read started for a fetch that should hit");

    a_miss_burst: assert property (@(posedge clk) disable iff (rst)
        fetch_acc && !exp_hit |-> ##2 arvalid)
        else stop_on_error("miss or uncached fetch did not start a read");

    a_maint_ready: assert property (@(posedge clk) disable iff (rst)
        maint_acc |=> !maint_ready ##1 maint_ready)
        else stop_on_error("maint_ready not back two cycles after acceptance");

    // 200 cycles per request plus reset
    initial begin
        #((N_REQ * CYC_PER_REQ + 20) * CLK_PERIOD);
        stop_on_error($sformatf("timeout after %0d cycles", N_REQ * CYC_PER_REQ + 20));
    end

    initial begin
        void'($urandom(13003));
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch_req   = '0;
        maint_valid = 1'b0;
        maint_op    = '0;
        exp_hit     = 1'b0;
        exp_data    = '0;
        exp_araddr  = '0;
        exp_arlen   = '0;
        for (int s = 0; s < 16; s++) begin
            m_plru[s] = 3'b000;
            for (int w = 0; w < 4; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w]   = '0;
            end
        end
        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;
        step_cycle();
        run_cold_and_hits();
        run_uncached();
        run_plru();
        run_maint();
        run_random();
        $display("Done: no errors");
        $finish;
    end

endmodule
